/* project.f */
logic/cpu_pkg.sv
logic/cache_pkg.sv
logic/mem_access.sv
logic/dcache_fsm.sv
logic/dcache_arrays.sv
logic/mem_reg.sv
logic/mem_stage.sv
verification/l2_model.sv
verification/tb_mem_stage.sv

/* verification/tb_mem_stage.sv */
`timescale 1ns/1ps

module tb_mem_stage;
    import cpu_pkg::*;
    import cache_pkg::*;

    localparam int period       = 20;
    localparam int reset_cycles = 10;
    localparam int max_accesses = 80;     // upper bound of accesses in the run
    localparam int miss_cycles  = 2 * 6;  // write-back plus refill transfer
    localparam int limit_cycles = 2 * reset_cycles + max_accesses * (miss_cycles + 6) + 200;

    logic        clk;
    logic        rst;
    logic        stall;
    logic        flush;
    ex_mem_t     ex_mem;
    logic        l2_rdy;
    line_t       l2_rd_line;
    logic        miss_stall;
    logic [31:0] fwd_data;
    mem_wb_t     mem_wb;
    logic        drq;
    l2_req_t     l2_req;

    logic [31:0] ref_mem [16384];  // word image below 64 KiB
    int          seed = 99;
    int          checks;
    int          errors;

    bit          saw_miss;         // l2 traffic of the last access
    bit          drq_seen;
    bit          wb_seen;
    bit          rd_seen;
    bit          wb_before_rd;
    logic [31:0] wb_addr;
    line_t       wb_line;
    logic [31:0] rd_addr;

    mem_stage i_dut (
        .clk        (clk),
        .rst        (rst),
        .stall      (stall),
        .flush      (flush),
        .ex_mem     (ex_mem),
        .l2_rdy     (l2_rdy),
        .l2_rd_line (l2_rd_line),
        .miss_stall (miss_stall),
        .fwd_data   (fwd_data),
        .mem_wb     (mem_wb),
        .drq        (drq),
        .l2_req     (l2_req)
    );

    l2_model #(.delay(4)) i_l2 (
        .clk        (clk),
        .rst        (rst),
        .drq        (drq),
        .l2_req     (l2_req),
        .l2_rdy     (l2_rdy),
        .l2_rd_line (l2_rd_line)
    );

    initial begin
        clk = 1'b0;
        forever #(period / 2) clk = ~clk;
    end

    initial begin
        #(limit_cycles * period);
        $display("watchdog expired before the tests finished");
        $display("checks %0d errors %0d", checks, errors);
        $display("** FAIL **");
        $finish;
    end

    // drq drops in the cycle after the strobe
    drq_drop: assert property (@(posedge clk) disable iff (rst) l2_rdy |=> !drq)
        else begin
            errors++;
            $display("[ERROR] l2_rule drq still high after l2_rdy");
        end

    drq_hold: assert property (@(posedge clk) disable iff (rst)
                               drq && !l2_rdy |=> drq && $stable(l2_req))
        else begin
            errors++;
            $display("[ERROR] l2_rule request dropped or changed before l2_rdy");
        end

    function automatic logic [31:0] init_word(logic [31:0] a);
        return (a * 32'h9e37_79b1) ^ 32'h5a5a_0f0f;  // same fill as the l2 model
    endfunction

    function automatic logic [31:0] make_addr(int tag, int set, int word);
        return (tag << 12) | (set << 4) | (word << 2);
    endfunction

    function automatic logic [31:0] rand_addr();
        logic [31:0] r;
        r = $random(seed);
        return make_addr(r[1:0], r[3:2], r[5:4]);  // 4 tags on 4 sets so conflicts are likely
    endfunction

    function automatic ex_mem_t pack_request(mem_op_e op, logic [31:0] addr,
                                             logic [31:0] data);
        ex_mem_t r;
        r          = '0;
        r.en       = 1'b1;
        r.op       = op;
        r.addr     = addr;
        r.wr_data  = data;
        r.dst_addr = addr[6:2];  // gpr tied to the address
        r.gpr_we   = (op == LW);
        return r;
    endfunction

    function automatic void check_value(string name, logic [63:0] expv, logic [63:0] actv);
        checks++;
        assert (actv === expv)
            else begin
                errors++;
                $display("[ERROR] %s expected %0h actual %0h", name, expv, actv);
            end
    endfunction

    function automatic void expect_true(string name, bit cond, string what);
        checks++;
        assert (cond)
            else begin
                errors++;
                $display("[ERROR] %s %s", name, what);
            end
    endfunction

    function automatic void note_l2();
        if (drq) begin
            drq_seen = 1'b1;
            if (l2_req.rw) begin
                if (!wb_seen) begin
                    wb_addr = l2_req.addr;  // first write-back of this access
                    wb_line = l2_req.line;
                end
                wb_seen = 1'b1;
            end else begin
                if (!rd_seen) begin
                    wb_before_rd = wb_seen;
                    rd_addr      = l2_req.addr;
                end
                rd_seen = 1'b1;
            end
        end
    endfunction

    task automatic apply_reset();
        rst    = 1'b1;
        ex_mem = '0;
        repeat (reset_cycles) @(negedge clk);
        rst = 1'b0;
        #(period / 4);
        expect_true("pipe_ctrl", !miss_stall && !drq, "miss_stall or drq high after reset");
        check_value("pipe_ctrl reset en", 0, mem_wb.en);
        check_value("pipe_ctrl reset gpr_we", 0, mem_wb.gpr_we);
    endtask

    // one access held until miss_stall falls and checked after the edge
    task automatic run_access(input string name, input mem_op_e op,
                              input logic [31:0] addr, input logic [31:0] data);
        logic [31:0] expv;
        bit          misaligned;
        misaligned   = (addr[1:0] != 2'b00);
        expv         = ref_mem[addr[15:2]];
        saw_miss     = 1'b0;
        drq_seen     = 1'b0;
        wb_seen      = 1'b0;
        rd_seen      = 1'b0;
        wb_before_rd = 1'b0;
        @(negedge clk);
        ex_mem = pack_request(op, addr, data);
        #(period / 4);  // comb outputs settled
        while (miss_stall) begin
            saw_miss = 1'b1;
            note_l2();
            @(negedge clk);
            #(period / 4);
        end
        note_l2();
        if (op == LW && !misaligned) begin
            check_value({name, " fwd_data"}, expv, fwd_data);
        end
        @(negedge clk);  // result now registered
        ex_mem = '0;
        check_value({name, " en"}, 1, mem_wb.en);
        if (misaligned) begin
            check_value({name, " exp"}, EXP_MISALIGN, mem_wb.exp);
            check_value({name, " gpr_we"}, 0, mem_wb.gpr_we);
        end else begin
            check_value({name, " exp"}, EXP_NONE, mem_wb.exp);
            check_value({name, " dst_addr"}, addr[6:2], mem_wb.dst_addr);
            check_value({name, " gpr_we"}, op == LW, mem_wb.gpr_we);
            if (op == LW) begin
                check_value({name, " out"}, expv, mem_wb.out);
            end else begin
                ref_mem[addr[15:2]] = data;
            end
        end
    endtask

    initial begin
        logic [31:0] a_miss;
        logic [31:0] a_fresh;
        logic [31:0] a_pipe;
        logic [31:0] a_reset;
        logic [31:0] a_evict [3];
        logic [31:0] la;
        logic [31:0] r;
        mem_wb_t     held;

        checks = 0;
        errors = 0;
        rst    = 1'b1;
        stall  = 1'b0;
        flush  = 1'b0;
        ex_mem = '0;
        for (int i = 0; i < 16384; i++) begin
            ref_mem[i] = init_word(i << 2);
        end
        apply_reset();

        a_miss = make_addr(1, 16, 2);  // set untouched so far
        run_access("load_miss", LW, a_miss, '0);
        expect_true("load_miss", saw_miss && rd_seen && !wb_seen, "no clean refill request");
        check_value("load_miss l2 addr", {a_miss[31:4], 4'h0}, rd_addr);

        run_access("load_hit", LW, a_miss, '0);
        expect_true("load_hit", !saw_miss && !drq_seen, "resident load went to l2");
        run_access("load_hit", LW, {a_miss[31:4], 4'h0}, '0);
        expect_true("load_hit", !saw_miss && !drq_seen, "resident load went to l2");

        run_access("store_load", SW, a_miss, 32'hcafe_0001);
        expect_true("store_load", !saw_miss, "store to a resident line missed");
        run_access("store_load", LW, a_miss, '0);
        check_value("store_load value", 32'hcafe_0001, mem_wb.out);
        a_fresh = make_addr(2, 40, 3);
        run_access("store_load", SW, a_fresh, 32'h1234_5678);  // write allocate
        expect_true("store_load", saw_miss, "cold store did not miss");
        run_access("store_load", LW, a_fresh, '0);
        check_value("store_load value", 32'h1234_5678, mem_wb.out);

        for (int t = 0; t < 3; t++) begin
            a_evict[t] = make_addr(t + 2, 32, 1);
            run_access("dirty_evict", SW, a_evict[t], 32'hd000_0000 + t);
        end
        la = {a_evict[0][31:4], 4'h0};  // oldest line is the victim
        expect_true("dirty_evict", wb_seen && wb_before_rd, "no write-back ahead of the refill");
        check_value("dirty_evict wb addr", la, wb_addr);
        for (int w = 0; w < 4; w++) begin
            check_value("dirty_evict wb data", ref_mem[la[15:2] + w], wb_line[w]);
        end
        run_access("dirty_evict", LW, a_evict[0], '0);
        check_value("dirty_evict reload", 32'hd000_0000, mem_wb.out);

        run_access("misalign", LW, a_miss + 1, '0);
        expect_true("misalign", !saw_miss && !drq_seen, "misaligned load reached the cache");
        run_access("misalign", SW, a_miss + 2, 32'hbad0_0bad);
        expect_true("misalign", !saw_miss && !drq_seen, "misaligned store reached the cache");
        run_access("misalign", LW, a_miss, '0);  // word left untouched

        a_pipe = {a_miss[31:4], 4'h0};
        @(negedge clk);
        ex_mem = pack_request(LW, a_pipe, '0);
        @(negedge clk);
        held   = mem_wb;
        check_value("pipe_ctrl load", ref_mem[a_pipe[15:2]], held.out);
        ex_mem = pack_request(LW, a_pipe + 4, '0);
        stall  = 1'b1;
        repeat (3) begin
            @(negedge clk);
            check_value("pipe_ctrl stall", held, mem_wb);
        end
        stall = 1'b0;
        @(negedge clk);
        check_value("pipe_ctrl release", ref_mem[a_pipe[15:2] + 1], mem_wb.out);
        flush = 1'b1;
        @(negedge clk);
        check_value("pipe_ctrl flush en", 0, mem_wb.en);
        flush  = 1'b0;
        ex_mem = '0;

        for (int n = 0; n < 30; n++) begin
            r = $random(seed);
            run_access("random", r[0] ? SW : LW, rand_addr(), $random(seed));
        end

        a_reset = make_addr(1, 48, 1);
        run_access("pipe_ctrl", LW, a_reset, '0);
        apply_reset();  // valid bits cleared again
        run_access("pipe_ctrl", LW, a_reset, '0);
        expect_true("pipe_ctrl", saw_miss, "cache kept a line across reset");

        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

/* verification/l2_model.sv */
`timescale 1ns/1ps

module l2_model #(
    parameter int delay = 4  // cycles from drq to l2_rdy
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               drq,         // level request from the cache
    input  cache_pkg::l2_req_t l2_req,
    output logic               l2_rdy,      // one cycle strobe
    output cache_pkg::line_t   l2_rd_line
);
    import cache_pkg::*;

    localparam int depth = 4096;  // lines below 64 KiB

    line_t lines [depth];
    int    cnt;                   // cycles since drq rose

    function automatic logic [31:0] init_word(logic [31:0] a);
        return (a * 32'h9e37_79b1) ^ 32'h5a5a_0f0f;  // whole address mixed in
    endfunction

    initial begin
        l2_rdy = 1'b0;
        cnt    = 0;
        for (int i = 0; i < depth; i++) begin
            for (int w = 0; w < 4; w++) begin
                lines[i][w] = init_word((i << 4) | (w << 2));
            end
        end
    end

    always @(posedge clk) begin
        if (rst) begin
            l2_rdy <= 1'b0;
            cnt    <= 0;
        end else begin
            l2_rdy <= 1'b0;  // strobe drops by default
            if (drq && !l2_rdy) begin
                if (cnt == delay - 1) begin
                    l2_rdy <= 1'b1;
                    cnt    <= 0;
                end else begin
                    cnt <= cnt + 1;
                end
            end
            if (drq && l2_rdy && l2_req.rw) begin
                lines[l2_req.addr[15:4]] <= l2_req.line;  // victim line accepted
            end
        end
    end

    // read data follows the request address
    assign l2_rd_line = lines[l2_req.addr[15:4]];

endmodule

/* logic/mem_stage.sv */
`timescale 1ns/1ps

module mem_stage (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       stall,
    input  logic                       flush,
    input  cpu_pkg::ex_mem_t           ex_mem,
    input  logic                       l2_rdy,
    input  cache_pkg::line_t           l2_rd_line,
    output logic                       miss_stall,
    output logic [cpu_pkg::word_w-1:0] fwd_data,  // load word in the same cycle
    output cpu_pkg::mem_wb_t           mem_wb,
    output logic                       drq,
    output cache_pkg::l2_req_t         l2_req
);
    import cpu_pkg::*;
    import cache_pkg::*;

    logic                              access;
    logic                              wr;
    logic [index_w-1:0]                index;
    logic [tag_w-1:0]                  tag;
    logic [word_w-1:0]                 rd_word;
    line_t                             st_line;
    mem_exp_e                          exp;
    logic                              hit;
    line_t                             hit_line;
    logic [ways-1:0][tag_w-1:0]        way_tag;
    logic [ways-1:0]                   way_valid;
    logic [ways-1:0]                   way_dirty;
    line_t [ways-1:0]                  way_line;
    logic                              lru;
    logic [ways-1:0]                   line_we;
    line_t                             wr_line;
    logic [tag_w-1:0]                  wr_tag;
    logic                              wr_dirty;
    logic                              lru_we;
    logic                              lru_wd;

    assign fwd_data = rd_word;

    mem_access i_access (
        .ex_mem   (ex_mem),
        .hit      (hit),
        .hit_line (hit_line),
        .access   (access),
        .wr       (wr),
        .index    (index),
        .tag      (tag),
        .word_sel (),
        .rd_word  (rd_word),
        .st_line  (st_line),
        .exp      (exp)
    );

    dcache_fsm i_fsm (
        .clk        (clk),
        .rst        (rst),
        .access     (access),
        .wr         (wr),
        .index      (index),
        .tag        (tag),
        .st_line    (st_line),
        .way_tag    (way_tag),
        .way_valid  (way_valid),
        .way_dirty  (way_dirty),
        .way_line   (way_line),
        .lru        (lru),
        .l2_rdy     (l2_rdy),
        .l2_rd_line (l2_rd_line),
        .hit        (hit),
        .hit_line   (hit_line),
        .miss_stall (miss_stall),
        .line_we    (line_we),
        .wr_line    (wr_line),
        .wr_tag     (wr_tag),
        .wr_dirty   (wr_dirty),
        .lru_we     (lru_we),
        .lru_wd     (lru_wd),
        .drq        (drq),
        .l2_req     (l2_req)
    );

    dcache_arrays i_arrays (
        .clk       (clk),
        .rst       (rst),
        .index     (index),
        .line_we   (line_we),
        .wr_line   (wr_line),
        .wr_tag    (wr_tag),
        .wr_dirty  (wr_dirty),
        .lru_we    (lru_we),
        .lru_wd    (lru_wd),
        .way_tag   (way_tag),
        .way_valid (way_valid),
        .way_dirty (way_dirty),
        .way_line  (way_line),
        .lru       (lru)
    );

    mem_reg i_mem_reg (
        .clk        (clk),
        .rst        (rst),
        .stall      (stall),
        .flush      (flush),
        .miss_stall (miss_stall),
        .ex_mem     (ex_mem),
        .out        (rd_word),
        .exp        (exp),
        .mem_wb     (mem_wb)
    );

endmodule

/* logic/mem_reg.sv */
`timescale 1ns/1ps

module mem_reg (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       stall,       // hold
    input  logic                       flush,       // bubble
    input  logic                       miss_stall,  // bubble while the cache refills
    input  cpu_pkg::ex_mem_t           ex_mem,
    input  logic [cpu_pkg::word_w-1:0] out,
    input  cpu_pkg::mem_exp_e          exp,
    output cpu_pkg::mem_wb_t           mem_wb
);
    import cpu_pkg::*;

    always_ff @(posedge clk) begin
        if (rst) begin
            mem_wb <= '0;  // en and gpr_we low
        end else if (stall) begin
            mem_wb <= mem_wb;
        end else if (flush || miss_stall) begin
            mem_wb <= '0;
        end else begin
            mem_wb.en       <= ex_mem.en;
            mem_wb.dst_addr <= ex_mem.dst_addr;
            mem_wb.exp      <= exp;
            if (exp == EXP_MISALIGN) begin
                mem_wb.gpr_we <= 1'b0;  // no register write on exception
                mem_wb.out    <= '0;
            end else begin
                mem_wb.gpr_we <= ex_mem.gpr_we;
                mem_wb.out    <= out;
            end
        end
    end

endmodule

/* logic/dcache_arrays.sv */
`timescale 1ns/1ps

module dcache_arrays (
    input  logic                                             clk,
    input  logic                                             rst,
    input  logic [cache_pkg::index_w-1:0]                    index,    // set select
    input  logic [cache_pkg::ways-1:0]                       line_we,  // per way
    input  cache_pkg::line_t                                 wr_line,
    input  logic [cache_pkg::tag_w-1:0]                      wr_tag,
    input  logic                                             wr_dirty,
    input  logic                                             lru_we,
    input  logic                                             lru_wd,
    output logic [cache_pkg::ways-1:0][cache_pkg::tag_w-1:0] way_tag,
    output logic [cache_pkg::ways-1:0]                       way_valid,
    output logic [cache_pkg::ways-1:0]                       way_dirty,
    output cache_pkg::line_t [cache_pkg::ways-1:0]           way_line,
    output logic                                             lru
);
    import cache_pkg::*;

    logic [tag_w-1:0]            tag_mem   [ways][sets];
    line_t                       data_mem  [ways][sets];
    logic                        dirty_mem [ways][sets];  // only meaningful when valid
    logic [ways-1:0][sets-1:0]   valid_q;
    logic [sets-1:0]             lru_q;                   // 1 bit per set

    // storage, written with tag and dirty on every line write
    always_ff @(posedge clk) begin
        for (int w = 0; w < ways; w++) begin
            if (line_we[w]) begin
                tag_mem[w][index]   <= wr_tag;
                data_mem[w][index]  <= wr_line;
                dirty_mem[w][index] <= wr_dirty;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '0;  // cache empty after reset
            lru_q   <= '0;
        end else begin
            for (int w = 0; w < ways; w++) begin
                if (line_we[w]) begin
                    valid_q[w][index] <= 1'b1;
                end
            end
            if (lru_we) begin
                lru_q[index] <= lru_wd;
            end
        end
    end

    // async read of the indexed set
    always_comb begin
        for (int w = 0; w < ways; w++) begin
            way_tag[w]   = tag_mem[w][index];
            way_valid[w] = valid_q[w][index];
            way_dirty[w] = dirty_mem[w][index];
            way_line[w]  = data_mem[w][index];
        end
    end

    assign lru = lru_q[index];

endmodule

/* logic/dcache_fsm.sv */
`timescale 1ns/1ps

module dcache_fsm (
    input  logic                                             clk,
    input  logic                                             rst,
    input  logic                                             access,
    input  logic                                             wr,
    input  logic [cache_pkg::index_w-1:0]                    index,
    input  logic [cache_pkg::tag_w-1:0]                      tag,
    input  cache_pkg::line_t                                 st_line,     // merged store line
    input  logic [cache_pkg::ways-1:0][cache_pkg::tag_w-1:0] way_tag,
    input  logic [cache_pkg::ways-1:0]                       way_valid,
    input  logic [cache_pkg::ways-1:0]                       way_dirty,
    input  cache_pkg::line_t [cache_pkg::ways-1:0]           way_line,
    input  logic                                             lru,         // way to replace next
    input  logic                                             l2_rdy,      // one cycle strobe
    input  cache_pkg::line_t                                 l2_rd_line,
    output logic                                             hit,
    output cache_pkg::line_t                                 hit_line,
    output logic                                             miss_stall,
    output logic [cache_pkg::ways-1:0]                       line_we,
    output cache_pkg::line_t                                 wr_line,
    output logic [cache_pkg::tag_w-1:0]                      wr_tag,
    output logic                                             wr_dirty,
    output logic                                             lru_we,
    output logic                                             lru_wd,
    output logic                                             drq,
    output cache_pkg::l2_req_t                               l2_req
);
    import cache_pkg::*;

    dc_state_e        state;
    dc_state_e        state_nxt;
    logic [ways-1:0]  way_hit;
    logic             hit_way;
    logic             miss;
    logic             victim;     // way chosen at the lookup miss
    logic             gap;        // forces drq low after a transfer
    line_t            fill_line;  // refill buffer

    // tag compare
    always_comb begin
        for (int w = 0; w < ways; w++) begin
            way_hit[w] = way_valid[w] && (way_tag[w] == tag);
        end
    end

    assign hit_way    = way_hit[1];  // 2 ways only
    assign hit_line   = way_line[hit_way];
    assign hit        = access && (state == LOOKUP) && |way_hit;
    assign miss       = access && (state == LOOKUP) && !(|way_hit);
    assign miss_stall = miss || (state != LOOKUP);  // comb in the lookup cycle

    always_comb begin
        state_nxt = state;
        case (state)
            LOOKUP: begin
                if (miss) begin
                    // only a valid dirty victim needs writing back
                    state_nxt = (way_valid[lru] && way_dirty[lru]) ? WRITEBACK : ALLOCATE;
                end
            end
            WRITEBACK: if (drq && l2_rdy) state_nxt = ALLOCATE;
            ALLOCATE:  if (drq && l2_rdy) state_nxt = REFILL;
            REFILL:    state_nxt = LOOKUP;  // held access hits next cycle
            default:   state_nxt = LOOKUP;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= LOOKUP;
            gap   <= 1'b0;
        end else begin
            state <= state_nxt;
            gap   <= drq && l2_rdy;
        end
    end

    always_ff @(posedge clk) begin
        if (miss) begin
            victim <= lru;
        end
        if (state == ALLOCATE && l2_rdy) begin
            fill_line <= l2_rd_line;  // only valid in the rdy cycle
        end
    end

    // level request, low for one cycle after each rdy
    assign drq = (state == WRITEBACK || state == ALLOCATE) && !gap;

    always_comb begin
        l2_req.rw   = (state == WRITEBACK);
        l2_req.addr = {tag, index, {line_off_w{1'b0}}};                  // refill address
        if (state == WRITEBACK) begin
            l2_req.addr = {way_tag[victim], index, {line_off_w{1'b0}}};  // victim address
        end
        l2_req.line = way_line[victim];
    end

    // array write strobes
    always_comb begin
        line_we  = '0;
        wr_line  = st_line;
        wr_tag   = tag;
        wr_dirty = 1'b1;      // store hit marks the line dirty
        lru_we   = 1'b0;
        lru_wd   = ~hit_way;  // point at the other way
        if (state == REFILL) begin
            line_we[victim] = 1'b1;
            wr_line         = fill_line;
            wr_dirty        = 1'b0;  // clean after refill
        end else if (hit) begin
            line_we[hit_way] = wr;
            lru_we           = 1'b1;
        end
    end

endmodule

/* logic/mem_access.sv */
`timescale 1ns/1ps

module mem_access (
    input  cpu_pkg::ex_mem_t             ex_mem,
    input  logic                         hit,       // lookup hit from the fsm
    input  cache_pkg::line_t             hit_line,  // line of the hit way
    output logic                         access,    // valid aligned lw/sw
    output logic                         wr,
    output logic [cache_pkg::index_w-1:0] index,
    output logic [cache_pkg::tag_w-1:0]   tag,
    output logic [cache_pkg::offset_w-1:0] word_sel,
    output logic [cpu_pkg::word_w-1:0]    rd_word,
    output cache_pkg::line_t             st_line,
    output cpu_pkg::mem_exp_e            exp
);
    import cpu_pkg::*;
    import cache_pkg::*;

    logic mem_op;    // lw or sw in a live slot
    logic misalign;

    assign mem_op   = ex_mem.en && (ex_mem.op == LW || ex_mem.op == SW);
    assign misalign = |ex_mem.addr[byte_off_w-1:0];  // low bits must be zero
    assign access   = mem_op && !misalign;           // misaligned never reaches the cache
    assign wr       = (ex_mem.op == SW);

    // address split
    assign word_sel = ex_mem.addr[byte_off_w +: offset_w];
    assign index    = ex_mem.addr[line_off_w +: index_w];
    assign tag      = ex_mem.addr[line_off_w + index_w +: tag_w];

    assign exp = (mem_op && misalign) ? EXP_MISALIGN : EXP_NONE;

    // load word out of the hit line, zero otherwise
    assign rd_word = (hit && !wr) ? hit_line[word_sel] : '0;

    always_comb begin
        st_line           = hit_line;        // keep the other three words
        st_line[word_sel] = ex_mem.wr_data;  // merge the store word
    end

endmodule

/* logic/cache_pkg.sv */
package cache_pkg;

    // geometry of the 2-way L1 data cache
    localparam int ways       = 2;
    localparam int index_w    = 8;                   // 256 sets
    localparam int sets       = 1 << index_w;
    localparam int offset_w   = 2;                   // word within line
    localparam int byte_off_w = 2;                   // byte within word
    localparam int line_off_w = offset_w + byte_off_w;
    localparam int tag_w      = 20;                  // addr[31:12]
    localparam int line_w     = 128;

    // address split: tag | index | word | byte
    //                31:12 | 11:4 | 3:2  | 1:0

    typedef logic [(1 << offset_w)-1:0][cpu_pkg::word_w-1:0] line_t;  // 4 words

    typedef struct packed {
        logic                       rw;    // 1 = write back to l2
        logic [cpu_pkg::word_w-1:0] addr;  // line aligned
        line_t                      line;  // victim data on a write
    } l2_req_t;

    typedef enum logic [1:0] {
        LOOKUP    = 2'd0,  // tag compare, serves hits
        WRITEBACK = 2'd1,  // dirty victim out to l2
        ALLOCATE  = 2'd2,  // line read request
        REFILL    = 2'd3   // fill buffer into the array
    } dc_state_e;

endpackage

/* logic/cpu_pkg.sv */
package cpu_pkg;

    localparam int word_w     = 32;  // data and address width
    localparam int reg_addr_w = 5;   // gpr index

    // memory operation carried down from decode
    typedef enum logic [1:0] {
        NOP = 2'd0,
        LW  = 2'd1,  // word load
        SW  = 2'd2   // word store
    } mem_op_e;

    typedef enum logic [0:0] {
        EXP_NONE     = 1'b0,
        EXP_MISALIGN = 1'b1  // word access off a 4 byte boundary
    } mem_exp_e;

    typedef struct packed {
        logic                  en;        // slot holds a real instruction
        mem_op_e               op;
        logic [word_w-1:0]     addr;      // effective address from ex
        logic [word_w-1:0]     wr_data;   // store data
        logic [reg_addr_w-1:0] dst_addr;
        logic                  gpr_we;
    } ex_mem_t;

    typedef struct packed {
        logic                  en;
        logic [reg_addr_w-1:0] dst_addr;
        logic                  gpr_we;
        logic [word_w-1:0]     out;       // load result
        mem_exp_e              exp;
    } mem_wb_t;

endpackage
